// ==== spi_pkg.sv ====
package spi_pkg;

  // register access word layout
  localparam int ADDR_W     = 3;
  localparam int DATA_W     = 8;
  localparam int FRAME_BITS = 1 + ADDR_W + DATA_W;  // write flag, addr, data
  localparam int HEAD_BITS  = 1 + ADDR_W;           // read frame: flag + addr only

  // sclk = clk / (2 * HALF_PERIOD)
  localparam int HALF_PERIOD = 4;
  localparam int HP_CNT_W    = $clog2(2 * HALF_PERIOD);
  localparam int BIT_CNT_W   = $clog2(FRAME_BITS);

  // command queue
  localparam int CMD_DEPTH = 4;
  localparam int PTR_W     = $clog2(CMD_DEPTH);
  localparam int CNT_W     = $clog2(CMD_DEPTH + 1);

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    GAP,
    DELIVER
  } spi_state_e;

endpackage

// ==== spi_chan_if.sv ====
`timescale 1ns/1ps

// queue -> frame engine
interface cmd_if import spi_pkg::*; ();
  logic              valid;
  logic              ready;
  spi_op_e           op;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;

  modport source (
    output valid,
    output op,
    output addr,
    output wdata,
    input  ready
  );

  modport sink (
    input  valid,
    input  op,
    input  addr,
    input  wdata,
    output ready
  );
endinterface

// frame engine -> read-out register
interface rd_if import spi_pkg::*; ();
  logic              valid;
  logic              ready;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;

  modport source (
    output valid,
    output addr,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  addr,
    input  data,
    output ready
  );
endinterface

// ==== spi_cmd_queue.sv ====
`timescale 1ns/1ps

module spi_cmd_queue import spi_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  output logic              in_ready,
  input  spi_op_e           in_op,
  input  logic [ADDR_W-1:0] in_addr,
  input  logic [DATA_W-1:0] in_wdata,
  cmd_if.source             cmd
);

  spi_op_e           op_mem    [CMD_DEPTH];
  logic [ADDR_W-1:0] addr_mem  [CMD_DEPTH];
  logic [DATA_W-1:0] wdata_mem [CMD_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready = (count != CNT_W'(CMD_DEPTH));
  assign push     = in_valid && in_ready;
  assign pop      = cmd.valid && cmd.ready;

  // oldest entry, stable until popped
  assign cmd.valid = (count != '0);
  assign cmd.op    = op_mem[rd_ptr];
  assign cmd.addr  = addr_mem[rd_ptr];
  assign cmd.wdata = wdata_mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      op_mem[wr_ptr]    <= in_op;
      addr_mem[wr_ptr]  <= in_addr;
      wdata_mem[wr_ptr] <= in_wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

endmodule

// ==== spi_frame_engine.sv ====
`timescale 1ns/1ps

module spi_frame_engine import spi_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  cmd_if.sink  cmd,
  rd_if.source rd,
  output logic sclk,
  output logic cs_n,
  output logic mosi,
  input  logic miso
);

  spi_state_e state;
  spi_state_e state_nxt;

  logic [HP_CNT_W-1:0]   hp_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [FRAME_BITS-1:0] sreg;     // out at msb, miso in at lsb
  logic [ADDR_W-1:0]     addr_q;
  spi_op_e               op_q;

  logic start;
  logic half_tick;
  logic rise;
  logic fall;
  logic last_bit;
  logic gap_done;
  logic capture;
  logic in_bit;

  assign start     = cmd.valid && cmd.ready;
  assign half_tick = (state == SHIFT) && (hp_cnt == HP_CNT_W'(HALF_PERIOD - 1));
  assign rise      = half_tick && !sclk;
  assign fall      = half_tick && sclk;
  assign last_bit  = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));
  assign gap_done  = (state == GAP) && (hp_cnt == HP_CNT_W'(2 * HALF_PERIOD - 1));

  // read data phase starts once flag and address are out
  assign capture = (op_q == OP_READ) && (bit_cnt >= BIT_CNT_W'(HEAD_BITS));
  assign in_bit  = capture ? miso : 1'b0;

  assign cmd.ready = (state == IDLE);
  assign rd.valid  = (state == DELIVER);
  assign rd.addr   = addr_q;
  assign rd.data   = sreg[DATA_W-1:0];

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (cmd.valid)
          state_nxt = SHIFT;
      end
      SHIFT:
      begin
        if (fall && last_bit)
          state_nxt = GAP;
      end
      GAP:
      begin
        if (gap_done)
          state_nxt = (op_q == OP_READ) ? DELIVER : IDLE;
      end
      DELIVER:
      begin
        if (rd.ready)
          state_nxt = IDLE;
      end
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      hp_cnt  <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
    end
    else
    begin
      state <= state_nxt;

      // half period timer, reused to time the gap
      if (half_tick || gap_done || (state != SHIFT && state != GAP))
        hp_cnt <= '0;
      else
        hp_cnt <= hp_cnt + 1'b1;

      if (start)
      begin
        cs_n    <= 1'b0;
        bit_cnt <= '0;
        mosi    <= (cmd.op == OP_WRITE); // first bit ready before first rise
      end

      if (half_tick)
        sclk <= ~sclk;

      if (fall)
      begin
        if (last_bit)
        begin
          cs_n <= 1'b1;
          mosi <= 1'b0;
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
          mosi    <= sreg[FRAME_BITS-1]; // already shifted on the rise
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      op_q   <= cmd.op;
      addr_q <= cmd.addr;
      // data bits of a read go out as zeros
      sreg   <= {cmd.op == OP_WRITE, cmd.addr,
                 (cmd.op == OP_WRITE) ? cmd.wdata : {DATA_W{1'b0}}};
    end
    else if (rise)
    begin
      sreg <= {sreg[FRAME_BITS-2:0], in_bit};
    end
  end

endmodule

// ==== spi_read_out.sv ====
`timescale 1ns/1ps

module spi_read_out import spi_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  rd_if.sink                rd,
  output logic              out_valid,
  input  logic              out_ready,
  output logic [ADDR_W-1:0] out_addr,
  output logic [DATA_W-1:0] out_data
);

  logic              full;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;
  logic              load;

  // accept when empty or when the host drains this cycle
  assign rd.ready = !full || out_ready;
  assign load     = rd.valid && rd.ready;

  assign out_valid = full;
  assign out_addr  = addr_q;
  assign out_data  = data_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      full <= 1'b0;
    else if (load)
      full <= 1'b1;
    else if (out_ready)
      full <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      addr_q <= rd.addr;
      data_q <= rd.data;
    end
  end

endmodule

// ==== spi_ctrl_top.sv ====
`timescale 1ns/1ps

module spi_ctrl_top import spi_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  logic              cmd_write,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [DATA_W-1:0] cmd_wdata,
  output logic              sclk,
  output logic              cs_n,
  output logic              mosi,
  input  logic              miso,
  output logic              rd_valid,
  input  logic              rd_ready,
  output logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0] rd_data
);

  spi_op_e host_op;

  cmd_if cmd_ch ();
  rd_if  rd_ch ();

  assign host_op = cmd_write ? OP_WRITE : OP_READ;

  spi_cmd_queue u_queue (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (cmd_valid),
    .in_ready (cmd_ready),
    .in_op    (host_op),
    .in_addr  (cmd_addr),
    .in_wdata (cmd_wdata),
    .cmd      (cmd_ch.source)
  );

  spi_frame_engine u_engine (
    .clk   (clk),
    .rst_n (rst_n),
    .cmd   (cmd_ch.sink),
    .rd    (rd_ch.source),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso)
  );

  spi_read_out u_read_out (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd        (rd_ch.sink),
    .out_valid (rd_valid),
    .out_ready (rd_ready),
    .out_addr  (rd_addr),
    .out_data  (rd_data)
  );

endmodule

// ==== tb_spi_slave.sv ====
`timescale 1ns/1ps

module tb_spi_slave import spi_pkg::*; (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  logic [DATA_W-1:0]     regs [1 << ADDR_W];
  logic [FRAME_BITS-1:0] shift_in;
  logic [FRAME_BITS-1:0] frame_bits;   // last finished frame
  logic [ADDR_W-1:0]     cur_addr;
  logic                  cur_write;
  int                    pulse_cnt;
  int                    last_pulses;
  int                    frames_done;

  initial
  begin
    for (int i = 0; i < (1 << ADDR_W); i++)
      regs[i] = DATA_W'(i * 'h11 + 'h05);
    miso      = 1'b0;
    cur_write = 1'b1;
    shift_in  = '0;
  end

  always @(negedge cs_n)
  begin
    pulse_cnt = 0;
    shift_in  = '0;
    cur_write = 1'b1;
  end

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      shift_in = {shift_in[FRAME_BITS-2:0], mosi};
      pulse_cnt++;
      if (pulse_cnt == HEAD_BITS)   // flag and address are in
      begin
        cur_write = shift_in[HEAD_BITS-1];
        cur_addr  = shift_in[ADDR_W-1:0];
      end
    end
  end

  // read data goes out msb first, one bit per falling edge
  always @(negedge sclk)
  begin
    if (!cs_n && !cur_write && pulse_cnt >= HEAD_BITS && pulse_cnt < FRAME_BITS)
      miso <= regs[cur_addr][DATA_W - 1 - (pulse_cnt - HEAD_BITS)];
    else
      miso <= 1'b0;
  end

  always @(posedge cs_n)
  begin
    if (pulse_cnt != 0)
    begin
      frame_bits  = shift_in;
      last_pulses = pulse_cnt;
      if (pulse_cnt == FRAME_BITS && shift_in[FRAME_BITS-1])
        regs[shift_in[FRAME_BITS-2 -: ADDR_W]] = shift_in[DATA_W-1:0];
      frames_done++;
    end
  end

endmodule

// ==== tb_spi_ctrl.sv ====
`timescale 1ns/1ps

module tb_spi_ctrl import spi_pkg::*; ();

  localparam int FRAME_CYCLES = FRAME_BITS * 2 * HALF_PERIOD + 2 * HALF_PERIOD + 4;
  localparam int TEST_FRAMES  = 2 + 7 + (CMD_DEPTH + 2) + 3 + 3 + 40; // 3 extra for the stall hold
  localparam int MAX_CYCLES   = 2 * TEST_FRAMES * FRAME_CYCLES;
  localparam int FMT_ADDR     = 5;

  logic              clk;
  logic              rst_n;
  logic              cmd_valid;
  logic              cmd_ready;
  logic              cmd_write;
  logic [ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0] cmd_wdata;
  logic              sclk;
  logic              cs_n;
  logic              mosi;
  logic              miso;
  logic              rd_valid;
  logic              rd_ready;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;

  logic [DATA_W-1:0]     shadow [1 << ADDR_W];
  logic [FRAME_BITS-1:0] frame_log [$];
  int                    logged;
  int                    issued;
  int                    stall_cycles;
  int                    cycles;
  int                    seed_val;

  spi_ctrl_top dut (.*);

  tb_spi_slave slave (
    .sclk (sclk),
    .cs_n (cs_n),
    .mosi (mosi),
    .miso (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > MAX_CYCLES)
    begin
      $display("timeout: no progress after %0d clock cycles", cycles);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  always @(posedge clk)
  begin
    if (slave.frames_done != logged)
    begin
      frame_log.push_back(slave.frame_bits);
      logged++;
    end
  end

  function automatic logic [DATA_W-1:0] reset_value(input int a);
    return DATA_W'(a * 'h11 + 'h05);
  endfunction

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
    begin
      $display("Fail at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
      $display("Result: FAILED");
      $fatal(1, "check failed: %s", what);
    end
  endtask

  // call and return on a falling edge
  task automatic send_cmd(input logic write, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
    cmd_valid = 1'b1;
    cmd_write = write;
    cmd_addr  = addr;
    cmd_wdata = data;
    while (!cmd_ready)
    begin
      stall_cycles++;
      @(negedge clk);
    end
    @(negedge clk);
    cmd_valid = 1'b0;
    issued++;
    if (write)
      shadow[addr] = data;
  endtask

  task automatic take_result(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    while (!rd_valid)
      @(negedge clk);
    expect_eq("rd_addr", 32'(rd_addr), 32'(addr));
    expect_eq("rd_data", 32'(rd_data), 32'(data));
    rd_ready = 1'b1;
    @(negedge clk);
    rd_ready = 1'b0;
  endtask

  task automatic drain();
    while (slave.frames_done != issued)
      @(negedge clk);
  endtask

  task automatic reset_values();
    expect_eq("cs_n after reset", 32'(cs_n), 32'd1);
    expect_eq("sclk after reset", 32'(sclk), 32'd0);
    expect_eq("mosi after reset", 32'(mosi), 32'd0);
    expect_eq("cmd_ready after reset", 32'(cmd_ready), 32'd1);
    expect_eq("rd_valid after reset", 32'(rd_valid), 32'd0);
  endtask

  task automatic frame_format();
    send_cmd(1'b1, ADDR_W'(FMT_ADDR), 8'h3c);
    drain();
    expect_eq("write frame pulses", slave.last_pulses, FRAME_BITS);
    expect_eq("write frame bits", 32'(slave.frame_bits), 32'({1'b1, ADDR_W'(FMT_ADDR), 8'h3c}));
    send_cmd(1'b0, ADDR_W'(FMT_ADDR), 8'h00);
    take_result(ADDR_W'(FMT_ADDR), 8'h3c);
    expect_eq("read frame pulses", slave.last_pulses, FRAME_BITS);
  endtask

  task automatic untouched_reads();
    int a;
    for (a = 0; a < (1 << ADDR_W); a++)
    begin
      if (a != FMT_ADDR)
      begin
        send_cmd(1'b0, ADDR_W'(a), 8'h00);
        take_result(ADDR_W'(a), reset_value(a));
      end
    end
  endtask

  task automatic queue_fill();
    logic [DATA_W-1:0] data [CMD_DEPTH + 2];
    int i;
    drain();
    @(negedge clk);
    frame_log.delete();
    stall_cycles = 0;
    rd_ready = 1'b1;
    for (i = 0; i < CMD_DEPTH + 2; i++)
    begin
      data[i] = DATA_W'($urandom);
      send_cmd(1'b1, ADDR_W'(i), data[i]);
    end
    drain();
    @(negedge clk);
    rd_ready = 1'b0;
    expect_eq("cmd_ready dropped when full", 32'(stall_cycles != 0), 32'd1);
    for (i = 0; i < CMD_DEPTH + 2; i++)
    begin
      expect_eq("burst frame order", 32'(frame_log[i]), 32'({1'b1, ADDR_W'(i), data[i]}));
      expect_eq("slave register", 32'(slave.regs[i]), 32'(shadow[i]));
    end
  endtask

  task automatic result_backpressure();
    logic [ADDR_W-1:0] addrs [3];
    int base;
    int i;
    addrs[0] = 3'd1;
    addrs[1] = 3'd6;
    addrs[2] = 3'd3;
    base = slave.frames_done;
    for (i = 0; i < 3; i++)
      send_cmd(1'b0, addrs[i], 8'h00);
    while (slave.frames_done < base + 2)
      @(negedge clk);
    repeat (2 * FRAME_CYCLES) @(negedge clk);   // room for a third frame if not stalled
    expect_eq("frames while stalled", slave.frames_done - base, 2);
    expect_eq("rd_valid while stalled", 32'(rd_valid), 32'd1);
    expect_eq("held result addr", 32'(rd_addr), 32'(addrs[0]));
    for (i = 0; i < 3; i++)
      take_result(addrs[i], shadow[addrs[i]]);
  endtask

  task automatic random_mix();
    logic              is_write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    int n;
    for (n = 0; n < 40; n++)
    begin
      is_write = 1'($urandom_range(1, 0));
      addr     = ADDR_W'($urandom);
      data     = DATA_W'($urandom);
      send_cmd(is_write, addr, data);
      if (!is_write)
        take_result(addr, shadow[addr]);
    end
    drain();
    for (n = 0; n < (1 << ADDR_W); n++)
      expect_eq("slave register after mix", 32'(slave.regs[n]), 32'(shadow[n]));
  endtask

  initial
  begin
    seed_val  = $urandom(32'h5c9a);
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_write = 1'b0;
    cmd_addr  = '0;
    cmd_wdata = '0;
    rd_ready  = 1'b0;
    for (int a = 0; a < (1 << ADDR_W); a++)
      shadow[a] = reset_value(a);
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    reset_values();
    frame_format();
    untouched_reads();
    queue_fill();
    result_backpressure();
    random_mix();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== spi_ctrl.f ====
spi_pkg.sv
spi_chan_if.sv
spi_cmd_queue.sv
spi_frame_engine.sv
spi_read_out.sv
spi_ctrl_top.sv
tb_spi_slave.sv
tb_spi_ctrl.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the spi controller testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_spi_ctrl -f spi_ctrl.f -o tb_spi_ctrl
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_spi_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Result: PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
